//--- list.f
logic/radio_pkg.sv
logic/settings_port.sv
logic/timekeeper.sv
logic/rx_framer.sv
logic/pkt_out_port.sv
logic/radio_core_top.sv
tests/tb_radio_core.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = tb_radio_core
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TEST RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/tb_radio_core.sv
//////////////////////////////
// Radio core testbench with host and sink
// drivers, timekeeper and sample model,
// random streaming
//////////////////////////////
`default_nettype none

module tb_radio_core
  import radio_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] COMPAT_MAJOR   = 32'h0000_0002;
  localparam logic [31:0] COMPAT_MINOR   = 32'h0000_0005;
  localparam int          BUF_DEPTH_LOG2 = 6;
  localparam int          SEED           = 34608;
  // About four times the nominal run of 10k cycles
  localparam int          TIMEOUT_CYCLES = 40000;

  logic       ce_clk;
  logic       i_rst;
  logic       i_set_req;
  logic       i_set_wr;
  set_addr_t  i_set_addr;
  set_data_t  i_set_data;
  logic       o_set_ack;
  rb_data_t   o_rb_data;
  sample_t    i_rx;
  logic       i_rx_stb;
  logic       i_pps;
  logic       o_running;
  logic       o_pkt_req;
  pkt_word_t  o_pkt_data;
  logic       o_pkt_last;
  logic       i_pkt_ack;

  // Timekeeper model
  vita_time_t model_time;
  vita_time_t lastpps_m;
  vita_time_t pending_m;
  logic       armed_m;
  logic       pps_h1;
  logic       pps_h2;
  // Every strobed sample with its time
  vita_time_t samp_time[$];
  sample_t    samp_data[$];
  // Packet tracking
  int spp_m;
  int sink_max_delay;
  int pkt_word;
  int cur_start;
  int prev_start;
  int last_start;
  int last_end;
  int pkt_count;
  int skipped_m;
  int errors;
  int checks;
  int cycles = 0;
  logic stream_on;

  radio_core_top #(
    .COMPAT_MAJOR(COMPAT_MAJOR),
    .COMPAT_MINOR(COMPAT_MINOR),
    .BUF_DEPTH_LOG2(BUF_DEPTH_LOG2)
  ) dut0 (.*);

  initial begin
    ce_clk = 1'b0;
    forever #4 ce_clk = ~ce_clk;
  end

  always @(posedge ce_clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////
  function automatic int rand_below(input int n);
    return int'($urandom % n);
  endfunction

  task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                             input string what);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("** Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
    end
  endtask

  task automatic host_access(input logic wr, input set_addr_t addr, input set_data_t wdata,
                             output rb_data_t rdata);
    @(negedge ce_clk);
    i_set_wr   = wr;
    i_set_addr = addr;
    i_set_data = wdata;
    i_set_req  = 1'b1;
    while (!o_set_ack) @(negedge ce_clk);
    rdata     = o_rb_data;
    i_set_req = 1'b0;
    while (o_set_ack) @(negedge ce_clk);
  endtask

  task automatic host_write(input set_addr_t addr, input set_data_t wdata);
    rb_data_t rdata;
    host_access(1'b1, addr, wdata, rdata);
    check_value(rdata, 64'd0, "readback word on a write");
  endtask

  task automatic host_read(input set_addr_t addr, output rb_data_t rdata);
    host_access(1'b0, addr, 32'd0, rdata);
  endtask

  task automatic write_pending_time(input vita_time_t value);
    host_write(SR_TIME_HI, value[63:32]);
    host_write(SR_TIME_LO, value[31:0]);
    pending_m = value;
  endtask

  // One front-end cycle with the timekeeper model stepped alongside
  task automatic drive_cycle(input logic stb, input logic pps);
    sample_t data;
    logic    pps_edge;
    data = $urandom;
    @(negedge ce_clk);
    i_rx_stb = stb;
    i_pps    = pps;
    i_rx     = data;
    pps_edge = pps_h1 && !pps_h2;
    if (stb) begin
      samp_time.push_back(model_time);
      samp_data.push_back(data);
    end
    if (pps_edge) lastpps_m = armed_m ? pending_m : model_time;
    if (pps_edge && armed_m) begin
      model_time = pending_m;
      armed_m    = 1'b0;
    end else if (stb) begin
      model_time = model_time + 64'd1;
    end
    pps_h2 = pps_h1;
    pps_h1 = pps;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge ce_clk);
  endtask

  //////////////////////////////
  // Packet sink and checker
  //////////////////////////////
  task automatic take_word(input pkt_word_t word, input logic last);
    int s;
    if (pkt_word == 0) begin
      check_value(64'(last), 64'd0, "last flag on header word");
      if (samp_time.size() == 0 || word < samp_time[0] ||
          word - samp_time[0] >= 64'(samp_time.size())) begin
        errors++;
        $display("Packet header %0h matches no recorded sample time", word);
        cur_start = -1;
      end else begin
        cur_start = int'(word - samp_time[0]);
        if (prev_start >= 0) begin
          if (cur_start <= prev_start || (cur_start - prev_start) % spp_m != 0) begin
            errors++;
            $display("Packet at sample %0d does not start on a packet boundary", cur_start);
          end else begin
            skipped_m += (cur_start - prev_start) / spp_m - 1;
          end
        end
        prev_start = cur_start;
      end
      pkt_word = 1;
    end else begin
      s = cur_start + 2 * (pkt_word - 1);
      if (cur_start >= 0 && s + 1 < samp_data.size()) begin
        check_value(word, {samp_data[s], samp_data[s + 1]}, "sample pair");
      end
      check_value(64'(last), 64'(pkt_word == spp_m / 2), "last flag");
      if (last || pkt_word == spp_m / 2) begin
        pkt_count++;
        last_start = cur_start;
        last_end   = cur_start + spp_m - 1;
        pkt_word   = 0;
      end else begin
        pkt_word++;
      end
    end
  endtask

  task automatic sink_loop();
    int delay;
    forever begin
      @(negedge ce_clk);
      if (o_pkt_req && !i_pkt_ack) begin
        delay = rand_below(sink_max_delay + 1);
        repeat (delay) @(negedge ce_clk);
        take_word(o_pkt_data, o_pkt_last);
        i_pkt_ack = 1'b1;
      end else if (!o_pkt_req && i_pkt_ack) begin
        i_pkt_ack = 1'b0;
      end
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    rb_data_t   rb;
    vita_time_t loaded;
    int         n;
    int         n_before;
    int         n_after;
    int         idle;
    logic       stb;
    void'($urandom(SEED));
    i_rst = 1'b1;
    i_set_req = 1'b0;
    i_set_wr = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_rx = '0;
    i_rx_stb = 1'b0;
    i_pps = 1'b0;
    i_pkt_ack = 1'b0;
    model_time = '0;
    lastpps_m = '0;
    pending_m = '0;
    armed_m = 1'b0;
    pps_h1 = 1'b0;
    pps_h2 = 1'b0;
    spp_m = SPP_DEFAULT;
    sink_max_delay = 1;
    pkt_word = 0;
    cur_start = -1;
    prev_start = -1;
    last_start = -1;
    last_end = -1;
    pkt_count = 0;
    skipped_m = 0;
    errors = 0;
    checks = 0;
    stream_on = 1'b0;
    fork
      sink_loop();
    join_none
    wait_cycles(16);
    i_rst = 1'b0;

    // Reset state and readback mux
    check_value(64'(o_running), 64'd0, "run output after reset");
    host_read(RB_VITA_TIME, rb);
    check_value(rb, 64'd0, "time after reset");
    host_read(RB_VITA_LASTPPS, rb);
    check_value(rb, 64'd0, "last PPS after reset");
    host_read(RB_RX_STATUS, rb);
    check_value(rb, 64'd0, "RX status after reset");
    host_read(RB_COMPAT_NUM, rb);
    check_value(rb, {COMPAT_MAJOR, COMPAT_MINOR}, "compat number");
    host_read(8'h5A, rb);
    check_value(rb, 64'd0, "unknown readback address");

    // Immediate load then counted strobes
    loaded = {$urandom, $urandom};
    write_pending_time(loaded);
    host_write(SR_TIME_CTRL, 32'h1);
    model_time = loaded;
    n = 0;
    repeat (30 + rand_below(40)) begin
      stb = (rand_below(2) == 1);
      drive_cycle(stb, 1'b0);
      if (stb) n++;
    end
    drive_cycle(1'b0, 1'b0);
    host_read(RB_VITA_TIME, rb);
    check_value(rb, loaded + 64'(n), "time after immediate load");

    // Armed load at the PPS edge
    loaded = {$urandom, $urandom};
    write_pending_time(loaded);
    host_write(SR_TIME_CTRL, 32'h2);
    armed_m = 1'b1;
    repeat (10 + rand_below(10)) drive_cycle(rand_below(2) == 1, 1'b0);
    repeat (3) drive_cycle(rand_below(2) == 1, 1'b1);
    repeat (20) drive_cycle(rand_below(2) == 1, 1'b0);
    drive_cycle(1'b0, 1'b0);
    host_read(RB_VITA_LASTPPS, rb);
    check_value(rb, loaded, "last PPS equals pending time");
    check_value(rb, lastpps_m, "last PPS vs model");
    host_read(RB_VITA_TIME, rb);
    check_value(rb, model_time, "time after PPS load");
    // Unarmed edge only latches the running time
    repeat (5) drive_cycle(rand_below(2) == 1, 1'b1);
    repeat (10) drive_cycle(rand_below(2) == 1, 1'b0);
    drive_cycle(1'b0, 1'b0);
    host_read(RB_VITA_LASTPPS, rb);
    check_value(rb, lastpps_m, "last PPS on unarmed edge");
    host_read(RB_VITA_TIME, rb);
    check_value(rb, model_time, "time after unarmed edge");

    // Streaming, overflow under a slow sink, then stop
    spp_m = 16 + 2 * rand_below(25);
    host_write(SR_RX_SPP, 32'(spp_m));
    samp_time.delete();
    samp_data.delete();
    stream_on = 1'b1;
    n_before = 0;
    n_after = 0;
    fork
      begin
        while (stream_on) drive_cycle(rand_below(5) == 0, 1'b0);
        drive_cycle(1'b0, 1'b0);
      end
      begin
        host_write(SR_RX_CTRL, 32'h1);
        wait_cycles(2500);
        check_value(64'(o_running), 64'd1, "run output while streaming");
        sink_max_delay = 40;
        wait_cycles(2500);
        sink_max_delay = 1;
        wait_cycles(3000);
        n_before = samp_time.size();
        host_write(SR_RX_CTRL, 32'h0);
        n_after = samp_time.size();
        wait_cycles(1000);
        stream_on = 1'b0;
      end
    join
    // Drained once the output port stays quiet
    idle = 0;
    while (idle < 40) begin
      @(negedge ce_clk);
      idle = (o_pkt_req || i_pkt_ack) ? 0 : idle + 1;
    end
    check_value(64'(o_running), 64'd0, "run output after stop");
    host_read(RB_RX_STATUS, rb);
    check_value(64'(rb[32]), 64'd0, "run bit readback after stop");
    check_value(64'(rb[31:0]), 64'(skipped_m), "overflow count vs skipped packets");
    check_value(64'(last_start < n_after), 64'd1, "no packet starts after run cleared");
    check_value(64'(last_end >= n_before - 1), 64'd1, "packet in flight at stop completed");
    if (pkt_count < 10) begin
      errors++;
      $display("Only %0d packets were received", pkt_count);
    end
    if (skipped_m == 0) begin
      errors++;
      $display("No packets were dropped while the sink was slow");
    end

    $display("Checks: %0d, packets: %0d, dropped: %0d, SPP: %0d, errors: %0d",
             checks, pkt_count, skipped_m, spp_m, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/radio_core_top.sv
//////////////////////////////
// Radio core top: one RX channel with
// control port, timekeeper, framer, output
//////////////////////////////
`default_nettype none

module radio_core_top
  import radio_pkg::*;
#(
  parameter logic [31:0] COMPAT_MAJOR   = 32'h1,
  parameter logic [31:0] COMPAT_MINOR   = 32'h0,
  parameter int          BUF_DEPTH_LOG2 = 6
) (
  input  wire             ce_clk,
  input  wire             i_rst,
  // Host control
  input  wire             i_set_req,
  input  wire             i_set_wr,
  input  wire set_addr_t  i_set_addr,
  input  wire set_data_t  i_set_data,
  output logic            o_set_ack,
  output rb_data_t        o_rb_data,
  // Front end
  input  wire sample_t    i_rx,
  input  wire             i_rx_stb,
  input  wire             i_pps,
  output logic            o_running,
  // Packet output
  output logic            o_pkt_req,
  output pkt_word_t       o_pkt_data,
  output logic            o_pkt_last,
  input  wire             i_pkt_ack
);

  logic        set_stb;
  set_addr_t   set_addr;
  set_data_t   set_data;
  vita_time_t  vita_time;
  vita_time_t  vita_time_lastpps;
  logic [31:0] overflow_cnt;
  logic        buf_valid;
  pkt_word_t   buf_data;
  logic        buf_last;
  logic        buf_pop;

  settings_port #(
    .COMPAT_MAJOR(COMPAT_MAJOR),
    .COMPAT_MINOR(COMPAT_MINOR)
  ) u_settings_port (
    .ce_clk(ce_clk), .i_rst(i_rst),
    .i_set_req(i_set_req), .i_set_wr(i_set_wr),
    .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .o_set_ack(o_set_ack), .o_rb_data(o_rb_data),
    .i_vita_time(vita_time), .i_vita_time_lastpps(vita_time_lastpps),
    .i_overflow_cnt(overflow_cnt), .i_running(o_running),
    .o_set_stb(set_stb), .o_set_addr(set_addr), .o_set_data(set_data)
  );

  timekeeper u_timekeeper (
    .ce_clk(ce_clk), .i_rst(i_rst), .i_pps(i_pps), .i_rx_stb(i_rx_stb),
    .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
    .o_vita_time(vita_time), .o_vita_time_lastpps(vita_time_lastpps)
  );

  rx_framer #(
    .BUF_DEPTH_LOG2(BUF_DEPTH_LOG2)
  ) u_rx_framer (
    .ce_clk(ce_clk), .i_rst(i_rst),
    .i_rx(i_rx), .i_rx_stb(i_rx_stb), .i_vita_time(vita_time),
    .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
    .i_buf_pop(buf_pop),
    .o_running(o_running), .o_overflow_cnt(overflow_cnt),
    .o_buf_valid(buf_valid), .o_buf_data(buf_data), .o_buf_last(buf_last)
  );

  pkt_out_port u_pkt_out_port (
    .ce_clk(ce_clk), .i_rst(i_rst),
    .i_buf_valid(buf_valid), .i_buf_data(buf_data), .i_buf_last(buf_last),
    .i_pkt_ack(i_pkt_ack), .o_buf_pop(buf_pop),
    .o_pkt_req(o_pkt_req), .o_pkt_data(o_pkt_data), .o_pkt_last(o_pkt_last)
  );

endmodule

`default_nettype wire

//--- logic/pkt_out_port.sv
//////////////////////////////
// Packet output port: one buffered word
// per four-phase req/ack cycle
//////////////////////////////
`default_nettype none

module pkt_out_port
  import radio_pkg::*;
(
  input  wire             ce_clk,
  input  wire             i_rst,
  input  wire             i_buf_valid,
  input  wire pkt_word_t  i_buf_data,
  input  wire             i_buf_last,
  input  wire             i_pkt_ack,
  output logic            o_buf_pop,
  output logic            o_pkt_req,
  output pkt_word_t       o_pkt_data,
  output logic            o_pkt_last
);

  typedef enum logic [1:0] {ST_IDLE, ST_WAIT_ACK_HIGH, ST_WAIT_ACK_LOW} state_t;

  state_t state;

  // Take a word only once the previous handshake has fully closed
  assign o_buf_pop = (state == ST_IDLE) && i_buf_valid;

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      state     <= ST_IDLE;
      o_pkt_req <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (i_buf_valid) begin
            o_pkt_req <= 1'b1;
            state     <= ST_WAIT_ACK_HIGH;
          end
        end
        ST_WAIT_ACK_HIGH: begin
          if (i_pkt_ack) begin
            o_pkt_req <= 1'b0;
            state     <= ST_WAIT_ACK_LOW;
          end
        end
        ST_WAIT_ACK_LOW: begin
          if (!i_pkt_ack) state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Data held until the next word is taken
  always_ff @(posedge ce_clk) begin
    if (o_buf_pop) begin
      o_pkt_data <= i_buf_data;
      o_pkt_last <= i_buf_last;
    end
  end

endmodule

`default_nettype wire

//--- logic/rx_framer.sv
//////////////////////////////
// RX framer: run control, packet assembly,
// packet buffer and overflow count
//////////////////////////////
`default_nettype none

module rx_framer
  import radio_pkg::*;
#(
  parameter int BUF_DEPTH_LOG2 = 6
) (
  input  wire             ce_clk,
  input  wire             i_rst,
  input  wire sample_t    i_rx,
  input  wire             i_rx_stb,
  input  wire vita_time_t i_vita_time,
  input  wire             i_set_stb,
  input  wire set_addr_t  i_set_addr,
  input  wire set_data_t  i_set_data,
  input  wire             i_buf_pop,
  output logic            o_running,
  output logic [31:0]     o_overflow_cnt,
  output logic            o_buf_valid,
  output pkt_word_t       o_buf_data,
  output logic            o_buf_last
);

  localparam int PW = BUF_DEPTH_LOG2 + 1;
  localparam logic [PW-1:0] DEPTH = {1'b1, {BUF_DEPTH_LOG2{1'b0}}};

  typedef enum logic [1:0] {ST_IDLE, ST_HEADER, ST_PAIRING, ST_DROPPING} state_t;

  state_t          state;
  logic            run_cfg;
  spp_t            spp_cfg;
  spp_t            spp_act;
  spp_t            cnt;
  spp_t            cnt_next;
  sample_t         upper;
  logic [PW-1:0]   wr_ptr;
  logic [PW-1:0]   rd_ptr;
  logic [PW-1:0]   need;
  logic            room;
  logic            wr_en;
  logic            wr_last;
  pkt_word_t       wr_word;
  pkt_word_t       mem [2**BUF_DEPTH_LOG2];
  logic            last_mem [2**BUF_DEPTH_LOG2];

  assign o_running = (state != ST_IDLE);
  assign cnt_next  = cnt + 1'b1;
  // Header plus SPP/2 data words must fit
  assign need = PW'(spp_cfg[6:1]) + 1'b1;
  assign room = (DEPTH - (wr_ptr - rd_ptr)) >= need;

  // Buffer write: header on first sample, then one word per pair
  always_comb begin
    wr_en   = 1'b0;
    wr_last = 1'b0;
    wr_word = {upper, i_rx};
    if ((state == ST_HEADER) && run_cfg && i_rx_stb && room) begin
      wr_en   = 1'b1;
      wr_word = i_vita_time;
    end else if ((state == ST_PAIRING) && i_rx_stb && cnt[0]) begin
      wr_en   = 1'b1;
      wr_last = (cnt_next == spp_act);
    end
  end

  //////////////////////////////
  // Packet FSM
  //////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      state          <= ST_IDLE;
      run_cfg        <= 1'b0;
      spp_cfg        <= SPP_DEFAULT;
      spp_act        <= SPP_DEFAULT;
      cnt            <= '0;
      o_overflow_cnt <= '0;
    end else begin
      if (i_set_stb && (i_set_addr == SR_RX_CTRL)) run_cfg <= i_set_data[0];
      if (i_set_stb && (i_set_addr == SR_RX_SPP))  spp_cfg <= spp_t'(i_set_data);
      case (state)
        ST_IDLE: begin
          if (run_cfg) state <= ST_HEADER;
        end
        ST_HEADER: begin
          if (!run_cfg) begin
            state <= ST_IDLE;
          end else if (i_rx_stb) begin
            spp_act <= spp_cfg;
            cnt     <= 7'd1;
            if (room) begin
              state <= ST_PAIRING;
            end else begin
              // No room for the whole packet, drop it
              state          <= ST_DROPPING;
              o_overflow_cnt <= o_overflow_cnt + 32'd1;
            end
          end
        end
        default: begin
          if (i_rx_stb) begin
            cnt <= cnt_next;
            if (cnt_next == spp_act) state <= run_cfg ? ST_HEADER : ST_IDLE;
          end
        end
      endcase
    end
  end

  // Older sample of each pair
  always_ff @(posedge ce_clk) begin
    if (i_rx_stb) upper <= i_rx;
  end

  //////////////////////////////
  // Packet buffer
  //////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (i_buf_pop && o_buf_valid) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (wr_en) begin
      mem[wr_ptr[BUF_DEPTH_LOG2-1:0]]      <= wr_word;
      last_mem[wr_ptr[BUF_DEPTH_LOG2-1:0]] <= wr_last;
    end
  end

  assign o_buf_valid = (wr_ptr != rd_ptr);
  assign o_buf_data  = mem[rd_ptr[BUF_DEPTH_LOG2-1:0]];
  assign o_buf_last  = last_mem[rd_ptr[BUF_DEPTH_LOG2-1:0]];

endmodule

`default_nettype wire

//--- logic/timekeeper.sv
//////////////////////////////
// Timekeeper: sample-count time, immediate
// or PPS-aligned load, last PPS latch
//////////////////////////////
`default_nettype none

module timekeeper
  import radio_pkg::*;
(
  input  wire             ce_clk,
  input  wire             i_rst,
  input  wire             i_pps,
  input  wire             i_rx_stb,
  input  wire             i_set_stb,
  input  wire set_addr_t  i_set_addr,
  input  wire set_data_t  i_set_data,
  output vita_time_t      o_vita_time,
  output vita_time_t      o_vita_time_lastpps
);

  set_data_t  time_hi;
  set_data_t  time_lo;
  vita_time_t pending_time;
  logic       pps_armed;
  logic [1:0] pps_d;
  logic       pps_edge;
  logic       ctrl_stb;
  logic       load_now;
  logic       load_pps;

  assign pending_time = {time_hi, time_lo};
  // Edge seen one cycle after the input rises
  assign pps_edge = pps_d[0] & ~pps_d[1];
  assign ctrl_stb = i_set_stb && (i_set_addr == SR_TIME_CTRL);
  assign load_now = ctrl_stb && i_set_data[0];
  assign load_pps = pps_edge && pps_armed;

  // Pending time halves
  always_ff @(posedge ce_clk) begin
    if (i_set_stb && (i_set_addr == SR_TIME_HI)) time_hi <= i_set_data;
    if (i_set_stb && (i_set_addr == SR_TIME_LO)) time_lo <= i_set_data;
  end

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      pps_d               <= 2'b00;
      pps_armed           <= 1'b0;
      o_vita_time         <= '0;
      o_vita_time_lastpps <= '0;
    end else begin
      pps_d <= {pps_d[0], i_pps};
      if (load_pps) pps_armed <= 1'b0;
      // A new arm request wins over the clear
      if (ctrl_stb) pps_armed <= i_set_data[1];

      if (load_now || load_pps) o_vita_time <= pending_time;
      else if (i_rx_stb)        o_vita_time <= o_vita_time + 64'd1;

      if (pps_edge) o_vita_time_lastpps <= load_pps ? pending_time : o_vita_time;
    end
  end

endmodule

`default_nettype wire

//--- logic/settings_port.sv
//////////////////////////////
// Host control port: four-phase handshake,
// settings strobe and readback mux
//////////////////////////////
`default_nettype none

module settings_port
  import radio_pkg::*;
#(
  parameter logic [31:0] COMPAT_MAJOR = 32'h1,
  parameter logic [31:0] COMPAT_MINOR = 32'h0
) (
  input  wire             ce_clk,
  input  wire             i_rst,
  // Host side
  input  wire             i_set_req,
  input  wire             i_set_wr,
  input  wire set_addr_t  i_set_addr,
  input  wire set_data_t  i_set_data,
  output logic            o_set_ack,
  output rb_data_t        o_rb_data,
  // Readback sources
  input  wire vita_time_t i_vita_time,
  input  wire vita_time_t i_vita_time_lastpps,
  input  wire [31:0]      i_overflow_cnt,
  input  wire             i_running,
  // Internal settings bus
  output logic            o_set_stb,
  output set_addr_t       o_set_addr,
  output set_data_t       o_set_data
);

  typedef enum logic [1:0] {ST_IDLE, ST_ACT, ST_ACK, ST_RELEASE} state_t;

  state_t   state;
  rb_data_t rb_word;

  // Readback mux
  always_comb begin
    case (i_set_addr)
      RB_VITA_TIME:    rb_word = i_vita_time;
      RB_VITA_LASTPPS: rb_word = i_vita_time_lastpps;
      RB_RX_STATUS:    rb_word = {31'd0, i_running, i_overflow_cnt};
      RB_COMPAT_NUM:   rb_word = {COMPAT_MAJOR, COMPAT_MINOR};
      default:         rb_word = '0;
    endcase
  end

  //////////////////////////////
  // Handshake FSM
  //////////////////////////////
  always_ff @(posedge ce_clk) begin
    // Strobe lasts a single cycle
    o_set_stb <= 1'b0;
    if (i_rst) begin
      state     <= ST_IDLE;
      o_set_ack <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (i_set_req) state <= ST_ACT;
        end
        ST_ACT: begin
          o_set_ack <= 1'b1;
          o_set_stb <= i_set_wr;
          state     <= ST_ACK;
        end
        ST_ACK: begin
          if (!i_set_req) begin
            o_set_ack <= 1'b0;
            state     <= ST_RELEASE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Capture request and readback in the act cycle
  always_ff @(posedge ce_clk) begin
    if (state == ST_ACT) begin
      o_set_addr <= i_set_addr;
      o_set_data <= i_set_data;
      o_rb_data  <= i_set_wr ? '0 : rb_word;
    end
  end

endmodule

`default_nettype wire

//--- logic/radio_pkg.sv
//////////////////////////////
// Radio core package: data widths,
// settings and readback addresses, defaults
//////////////////////////////
`default_nettype none

package radio_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////
  typedef logic [31:0] sample_t;
  typedef logic [63:0] vita_time_t;
  typedef logic [7:0]  set_addr_t;
  typedef logic [31:0] set_data_t;
  typedef logic [63:0] rb_data_t;
  typedef logic [63:0] pkt_word_t;
  // Samples per packet, up to 64
  typedef logic [6:0]  spp_t;

  //////////////////////////////
  // Settings registers
  //////////////////////////////
  localparam set_addr_t SR_TIME_HI   = 8'h00;
  localparam set_addr_t SR_TIME_LO   = 8'h01;
  // Bit 0 loads now, bit 1 arms load at next PPS
  localparam set_addr_t SR_TIME_CTRL = 8'h02;
  localparam set_addr_t SR_RX_CTRL   = 8'h10;
  localparam set_addr_t SR_RX_SPP    = 8'h11;

  //////////////////////////////
  // Readback addresses
  //////////////////////////////
  localparam set_addr_t RB_VITA_TIME    = 8'h00;
  localparam set_addr_t RB_VITA_LASTPPS = 8'h01;
  // Overflow count in [31:0], run in [32]
  localparam set_addr_t RB_RX_STATUS    = 8'h02;
  localparam set_addr_t RB_COMPAT_NUM   = 8'h03;

  // Samples per packet out of reset
  localparam spp_t SPP_DEFAULT = 7'd16;

endpackage

`default_nettype wire
